// ==== include/lc3b_macros.svh ====
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// ##########################################################
// core-wide sizes
// ##########################################################

// data and address width, in bits.
`define LC3B_WORD_W 16

// architectural registers r0 to r7.
`define LC3B_NUM_REGS 8

// pc value loaded while rst is high.
`define LC3B_RESET_PC 16'h0000

`endif

// ==== logic/lc3b_types.sv ====
`include "lc3b_macros.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;              // data and addresses.
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;     // register index.
    typedef logic [2:0] lc3b_nzp;                            // condition code, n z p.

    // kept opcodes. any other value decodes as a no-op.
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass                                             // forwards operand a.
    } lc3b_aluop;

    // fetch to execute payload.
    typedef struct packed {
        lc3b_word ir;
        lc3b_word pc_next;                                   // pc + 2 of this instruction.
    } lc3b_if_ex;

    // execute to memory/writeback payload.
    typedef struct packed {
        lc3b_reg  dest;
        lc3b_word result;                                    // alu value or data address.
        lc3b_word store_data;
        logic     mem_read;
        logic     mem_write;
        logic     load_regfile;
        logic     load_cc;
    } lc3b_ex_mw;

endpackage : lc3b_types

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,       // hold everything.
    input  logic     flush,       // next contents become a bubble.
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else if (!stall) begin
            valid_out <= valid_in && !flush;
        end
    end

    // payload only matters while valid is set.
    always_ff @(posedge clk) begin
        if (!stall) data_out <= data_in;
    end

    // the stage driving flush must let a stall take priority.
    assert property (@(posedge clk) disable iff (rst) !(flush && stall));

endmodule : pipe_reg

// ==== logic/regfile.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,     // writeback strobe from mw.
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    lc3b_types::lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};                 // all registers start at zero.
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // write-through, so ex sees the value mw is writing this cycle.
    assign reg_a = (load && (src_a == dest)) ? in : regs[src_a];
    assign reg_b = (load && (src_b == dest)) ? in : regs[src_b];

endmodule : regfile

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module execute_unit (
    input  lc3b_types::lc3b_word  ir,
    input  lc3b_types::lc3b_word  pc_next,
    input  lc3b_types::lc3b_word  reg_a,         // sr1 or base register.
    input  lc3b_types::lc3b_word  reg_b,         // sr2 or store source.
    input  lc3b_types::lc3b_aluop aluop,
    input  logic                  alumux_sel,
    input  logic                  marmux_sel,
    input  lc3b_types::lc3b_nzp   nzp_now,       // cc after any same-cycle writeback.
    output lc3b_types::lc3b_word  result,
    output lc3b_types::lc3b_word  branch_target,
    output logic                  branch_enable
);

    lc3b_types::lc3b_word imm5;
    lc3b_types::lc3b_word offset6;
    lc3b_types::lc3b_word offset9;
    lc3b_types::lc3b_word alu_b;
    lc3b_types::lc3b_word alu_out;

    // sign extension of the instruction fields.
    assign imm5    = {{(`LC3B_WORD_W-5){ir[4]}}, ir[4:0]};
    assign offset6 = {{(`LC3B_WORD_W-6){ir[5]}}, ir[5:0]};
    assign offset9 = {{(`LC3B_WORD_W-9){ir[8]}}, ir[8:0]};

    assign alu_b = alumux_sel ? imm5 : reg_b;

    always_comb begin
        case (aluop)
            lc3b_types::alu_add: alu_out = reg_a + alu_b;
            lc3b_types::alu_and: alu_out = reg_a & alu_b;
            lc3b_types::alu_not: alu_out = ~reg_a;
            default:             alu_out = reg_a;      // pass.
        endcase
    end

    // word offsets, so both adders scale by two.
    assign result        = marmux_sel ? reg_a + (offset6 << 1) : alu_out;
    assign branch_target = pc_next + (offset9 << 1);
    assign branch_enable = |(ir[11:9] & nzp_now);    // any requested flag set.

endmodule : execute_unit

// ==== logic/control.sv ====
`timescale 1ns/1ns

module control (
    input  lc3b_types::lc3b_opcode opcode,
    input  logic                   imm_enable,
    output logic                   load_regfile,
    output logic                   load_cc,
    output logic                   mem_read_ex,
    output logic                   mem_write_ex,
    output logic                   is_branch,
    output lc3b_types::lc3b_aluop  aluop,
    output logic                   alumux_sel,    // 1 selects sext(imm5).
    output logic                   marmux_sel,    // 1 selects base + offset6.
    output logic                   storemux_sel   // 1 reads sr (11:9) on port b.
);

    always_comb begin
        // everything inactive, so unknown opcodes fall through as no-ops.
        load_regfile = 1'b0;
        load_cc      = 1'b0;
        mem_read_ex  = 1'b0;
        mem_write_ex = 1'b0;
        is_branch    = 1'b0;
        aluop        = lc3b_types::alu_pass;
        alumux_sel   = 1'b0;
        marmux_sel   = 1'b0;
        storemux_sel = 1'b0;

        case (opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                aluop        = (opcode == lc3b_types::op_add) ? lc3b_types::alu_add
                                                              : lc3b_types::alu_and;
                alumux_sel   = imm_enable;            // register or imm5 form.
            end
            lc3b_types::op_not: begin
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                aluop        = lc3b_types::alu_not;
            end
            lc3b_types::op_br: is_branch = 1'b1;   // condition tested in ex.
            lc3b_types::op_ldr: begin
                mem_read_ex  = 1'b1;
                load_regfile = 1'b1;
                load_cc      = 1'b1;                  // ldr sets cc from the loaded word.
                marmux_sel   = 1'b1;
            end
            lc3b_types::op_str: begin
                mem_write_ex = 1'b1;
                marmux_sel   = 1'b1;
                storemux_sel = 1'b1;
            end
            default: ;
        endcase

        // the datapath drives a single request level per access.
        assert (!(mem_read_ex && mem_write_ex))
            else $error("control: read and write decoded together.");
    end

endmodule : control

// ==== logic/datapath.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_regfile,
    input  logic                   load_cc,
    input  lc3b_types::lc3b_aluop  aluop,
    input  logic                   alumux_sel,
    input  logic                   marmux_sel,
    input  logic                   storemux_sel,
    input  logic                   mem_read_ex,
    input  logic                   mem_write_ex,
    input  logic                   is_branch,
    output lc3b_types::lc3b_opcode opcode,
    output logic                   imm_enable,
    input  logic                   mem_resp,
    input  lc3b_types::lc3b_word   mem_rdata,
    output logic                   mem_read,
    output logic                   mem_write,
    output lc3b_types::lc3b_word   mem_address,
    output lc3b_types::lc3b_word   mem_wdata,
    input  lc3b_types::lc3b_word   instr_rdata,
    output lc3b_types::lc3b_word   instr_address
);

    lc3b_types::lc3b_word  pc;
    lc3b_types::lc3b_word  pc_plus2;
    logic                  stall;           // mw access still waiting on mem_resp.
    logic                  branch_taken;
    logic                  branch_enable;
    logic                  if_ex_flush;
    lc3b_types::lc3b_if_ex if_ex_d;
    lc3b_types::lc3b_if_ex if_ex_q;
    logic                  if_ex_valid;
    lc3b_types::lc3b_ex_mw ex_mw_d;
    lc3b_types::lc3b_ex_mw ex_mw_q;
    logic                  ex_mw_valid;
    lc3b_types::lc3b_word  ir;
    lc3b_types::lc3b_reg   src_b;
    lc3b_types::lc3b_word  reg_a;
    lc3b_types::lc3b_word  reg_b;
    lc3b_types::lc3b_word  ex_result;
    lc3b_types::lc3b_word  branch_target;
    lc3b_types::lc3b_word  wb_value;
    logic                  wb_load;
    logic                  cc_load;
    lc3b_types::lc3b_nzp   cc;
    lc3b_types::lc3b_nzp   cc_new;
    lc3b_types::lc3b_nzp   nzp_now;

    // ##########################################################
    // fetch
    // ##########################################################

    assign pc_plus2      = pc + `LC3B_WORD_W'(2);
    assign instr_address = pc;
    assign if_ex_d       = '{ir: instr_rdata, pc_next: pc_plus2};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `LC3B_RESET_PC;
        end else if (!stall) begin
            pc <= branch_taken ? branch_target : pc_plus2;   // taken target wins.
        end
    end

    assign branch_taken = if_ex_valid && is_branch && branch_enable;
    assign if_ex_flush  = branch_taken && !stall;          // kills the wrong-path fetch.

    pipe_reg #(.payload_t(lc3b_types::lc3b_if_ex)) if_ex_reg (
        .clk(clk), .rst(rst), .stall(stall), .flush(if_ex_flush),
        .valid_in(1'b1), .data_in(if_ex_d),                 // fetch always has an instruction.
        .valid_out(if_ex_valid), .data_out(if_ex_q)
    );

    // ##########################################################
    // execute
    // ##########################################################

    assign ir         = if_ex_q.ir;
    assign opcode     = lc3b_types::lc3b_opcode'(ir[15:12]);
    assign imm_enable = ir[5];
    assign src_b      = storemux_sel ? ir[11:9] : ir[2:0];  // sr for str, sr2 otherwise.

    regfile regfile_module (
        .clk(clk), .rst(rst), .load(wb_load), .dest(ex_mw_q.dest), .in(wb_value),
        .src_a(ir[8:6]), .src_b(src_b), .reg_a(reg_a), .reg_b(reg_b)
    );

    execute_unit execute_module (
        .ir(ir), .pc_next(if_ex_q.pc_next), .reg_a(reg_a), .reg_b(reg_b),
        .aluop(aluop), .alumux_sel(alumux_sel), .marmux_sel(marmux_sel),
        .nzp_now(nzp_now), .result(ex_result), .branch_target(branch_target),
        .branch_enable(branch_enable)
    );

    always_comb begin
        ex_mw_d.dest         = ir[11:9];
        ex_mw_d.result       = ex_result;
        ex_mw_d.store_data   = reg_b;
        ex_mw_d.mem_read     = mem_read_ex;
        ex_mw_d.mem_write    = mem_write_ex;
        ex_mw_d.load_regfile = load_regfile;
        ex_mw_d.load_cc      = load_cc;
    end

    pipe_reg #(.payload_t(lc3b_types::lc3b_ex_mw)) ex_mw_reg (
        .clk(clk), .rst(rst), .stall(stall), .flush(1'b0),  // branches retire as no-ops.
        .valid_in(if_ex_valid), .data_in(ex_mw_d),
        .valid_out(ex_mw_valid), .data_out(ex_mw_q)
    );

    // ##########################################################
    // memory and writeback
    // ##########################################################

    assign stall    = ex_mw_valid && (ex_mw_q.mem_read || ex_mw_q.mem_write) && !mem_resp;
    assign wb_value = ex_mw_q.mem_read ? mem_rdata : ex_mw_q.result;
    assign wb_load  = ex_mw_valid && ex_mw_q.load_regfile && !stall;
    assign cc_load  = wb_load && ex_mw_q.load_cc;

    always_comb begin
        if (wb_value[`LC3B_WORD_W-1]) cc_new = 3'b100;        // negative.
        else if (wb_value == '0)      cc_new = 3'b010;        // zero.
        else                          cc_new = 3'b001;        // positive.
    end

    always_ff @(posedge clk) begin
        if (rst) cc <= 3'b010;
        else if (cc_load) cc <= cc_new;
    end

    assign nzp_now = cc_load ? cc_new : cc;                 // same-cycle bypass to br.

    assign mem_read    = ex_mw_valid && ex_mw_q.mem_read;
    assign mem_write   = ex_mw_valid && ex_mw_q.mem_write;
    assign mem_address = ex_mw_q.result;
    assign mem_wdata   = ex_mw_q.store_data;

    // a pending request keeps its level, address and data until mem_resp.
    assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) && !mem_resp |=>
            $stable(mem_read) && $stable(mem_write) &&
            $stable(mem_address) && $stable(mem_wdata));

    // once reset has been sampled the data port stays idle.
    assert property (@(posedge clk) rst && $past(rst) |-> !mem_read && !mem_write);

endmodule : datapath

// ==== logic/mp3.sv ====
`timescale 1ns/1ns

module mp3 (
    input  logic                 clk,
    input  logic                 rst,

    // data memory port.
    input  logic                 mem_resp,
    input  lc3b_types::lc3b_word mem_rdata,
    output logic                 mem_read,
    output logic                 mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata,

    // instruction memory port, answers in the same cycle.
    input  lc3b_types::lc3b_word instr_rdata,
    output lc3b_types::lc3b_word instr_address
);

    lc3b_types::lc3b_opcode opcode;              // ex instruction opcode.
    logic                   imm_enable;          // ex instruction bit 5.
    logic                   load_regfile;
    logic                   load_cc;
    lc3b_types::lc3b_aluop  aluop;
    logic                   alumux_sel;
    logic                   marmux_sel;
    logic                   storemux_sel;
    logic                   mem_read_ex;
    logic                   mem_write_ex;
    logic                   is_branch;

    control control_module (
        .opcode(opcode),
        .imm_enable(imm_enable),
        .load_regfile(load_regfile),
        .load_cc(load_cc),
        .mem_read_ex(mem_read_ex),
        .mem_write_ex(mem_write_ex),
        .is_branch(is_branch),
        .aluop(aluop),
        .alumux_sel(alumux_sel),
        .marmux_sel(marmux_sel),
        .storemux_sel(storemux_sel)
    );

    datapath datapath_module (
        .clk(clk),
        .rst(rst),
        .load_regfile(load_regfile),
        .load_cc(load_cc),
        .aluop(aluop),
        .alumux_sel(alumux_sel),
        .marmux_sel(marmux_sel),
        .storemux_sel(storemux_sel),
        .mem_read_ex(mem_read_ex),
        .mem_write_ex(mem_write_ex),
        .is_branch(is_branch),
        .opcode(opcode),
        .imm_enable(imm_enable),
        .mem_resp(mem_resp),
        .mem_rdata(mem_rdata),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .instr_rdata(instr_rdata),
        .instr_address(instr_address)
    );

endmodule : mp3

// ==== bench/lc3b_memory_model.sv ====
`timescale 1ns/1ns

module lc3b_memory_model #(
    parameter int ROM_WORDS = 64,
    parameter int RAM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,

    // instruction side, answers in the same cycle.
    input  lc3b_types::lc3b_word instr_address,
    output lc3b_types::lc3b_word instr_rdata,
    input  lc3b_types::lc3b_word rom [ROM_WORDS],

    // data side.
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  lc3b_types::lc3b_word mem_address,
    input  lc3b_types::lc3b_word mem_wdata,
    output logic                 mem_resp,
    output lc3b_types::lc3b_word mem_rdata,

    // one pulse per completed store.
    output logic                 store_valid,
    output lc3b_types::lc3b_word store_address,
    output lc3b_types::lc3b_word store_data
);

    localparam int ROM_AW = $clog2(ROM_WORDS);
    localparam int RAM_AW = $clog2(RAM_WORDS);

    lc3b_types::lc3b_word ram [RAM_WORDS];
    logic [RAM_AW-1:0]    ram_index;
    logic                 pending;            // request seen, latency already drawn.
    int                   wait_left;          // extra cycles still to wait.
    int                   delay;

    assign instr_rdata = rom[instr_address[ROM_AW:1]];    // word addressed.
    assign ram_index   = mem_address[RAM_AW:1];

    initial begin
        void'($urandom(14));                               // fixed latency sequence.
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] <= lc3b_types::lc3b_word'(i * 2) ^ 16'hc3c3;   // word at a holds a ^ c3c3.
        end
        mem_resp      <= 1'b0;
        mem_rdata     <= '0;
        pending       <= 1'b0;
        wait_left     <= 0;
        store_valid   <= 1'b0;
        store_address <= '0;
        store_data    <= '0;
    end

    always @(posedge clk) begin
        store_valid <= 1'b0;
        if (rst) begin
            mem_resp <= 1'b0;
            pending  <= 1'b0;
        end else if (mem_resp) begin
            // the access completes at this edge.
            mem_resp <= 1'b0;
            pending  <= 1'b0;
            if (mem_write) begin
                ram[ram_index] <= mem_wdata;
                store_valid    <= 1'b1;
                store_address  <= mem_address;
                store_data     <= mem_wdata;
            end
        end else if (mem_read || mem_write) begin
            delay = pending ? wait_left : int'($urandom % 4);   // 0 to 3 extra cycles.
            pending <= 1'b1;
            if (delay == 0) begin
                mem_resp  <= 1'b1;
                mem_rdata <= ram[ram_index];
            end else begin
                wait_left <= delay - 1;
            end
        end
    end

endmodule : lc3b_memory_model

// ==== bench/mp3_tb.sv ====
`timescale 1ns/1ns

module mp3_tb;

    localparam int                   ROM_WORDS  = 64;
    localparam int                   NUM_STORES = 11;
    localparam lc3b_types::lc3b_word HALT_PC    = 16'h0046;   // final br to self.
    // about 40 executed instructions plus 13 memory ops of up to 5 cycles each.
    localparam int                   TIMEOUT_CYCLES = 600;

    logic                 clk;
    logic                 rst;
    logic                 mem_resp;
    lc3b_types::lc3b_word mem_rdata;
    logic                 mem_read;
    logic                 mem_write;
    lc3b_types::lc3b_word mem_address;
    lc3b_types::lc3b_word mem_wdata;
    lc3b_types::lc3b_word instr_rdata;
    lc3b_types::lc3b_word instr_address;
    lc3b_types::lc3b_word rom [ROM_WORDS];
    lc3b_types::lc3b_word expected_address [NUM_STORES];
    lc3b_types::lc3b_word expected_data [NUM_STORES];
    logic                 store_valid;
    lc3b_types::lc3b_word store_address;
    lc3b_types::lc3b_word store_data;
    int                   store_count;
    int                   cycle_count;
    logic                 finished;
    logic                 request_waiting;    // previous cycle held an unanswered request.
    lc3b_types::lc3b_word held_address;
    lc3b_types::lc3b_word held_wdata;

    mp3 DUT (
        .clk(clk),
        .rst(rst),
        .mem_resp(mem_resp),
        .mem_rdata(mem_rdata),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .instr_rdata(instr_rdata),
        .instr_address(instr_address)
    );

    lc3b_memory_model #(.ROM_WORDS(ROM_WORDS)) memory (
        .clk(clk), .rst(rst), .instr_address(instr_address), .instr_rdata(instr_rdata),
        .rom(rom), .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata),
        .store_valid(store_valid), .store_address(store_address), .store_data(store_data)
    );

    // ##########################################################
    // failure reporting
    // ##########################################################

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic report_mismatch(input string name, input lc3b_types::lc3b_word got,
                                   input lc3b_types::lc3b_word expected);
        abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                            $time, name, got, expected));
    endtask

    // ##########################################################
    // program image and expected stores
    // ##########################################################

    initial begin
        rom = '{default: 16'h0000};         // opcode 0 with nzp 000 never branches.
        rom[0]  = 16'h1225;                 // add r1, r0, #5      r1 = 0005.
        rom[1]  = 16'h127d;                 // add r1, r1, #-3     r1 = 0002.
        rom[2]  = 16'h1441;                 // add r2, r1, r1      r2 = 0004.
        rom[3]  = 16'h56ac;                 // and r3, r2, #12     r3 = 0004.
        rom[4]  = 16'h98ff;                 // not r4, r3          r4 = fffb.
        rom[5]  = 16'h5b01;                 // and r5, r4, r1      r5 = 0002.
        rom[6]  = 16'h1c28;                 // add r6, r0, #8      store base.
        rom[7]  = 16'h7380;                 // str r1, r6, #0
        rom[8]  = 16'h7581;                 // str r2, r6, #1
        rom[9]  = 16'h7782;                 // str r3, r6, #2
        rom[10] = 16'h7983;                 // str r4, r6, #3
        rom[11] = 16'h7b84;                 // str r5, r6, #4
        rom[12] = 16'h1321;                 // add r1, r4, #1      r1 = fffc.
        rom[13] = 16'h7385;                 // str r1, r6, #5      data forwarded.
        rom[14] = 16'h659c;                 // ldr r2, r6, #28     preload at 0040 = c383.
        rom[15] = 16'h16a1;                 // add r3, r2, #1      r3 = c384.
        rom[16] = 16'h7786;                 // str r3, r6, #6
        rom[17] = 16'h6983;                 // ldr r4, r6, #3      reads back fffb.
        rom[18] = 16'h9b3f;                 // not r5, r4          r5 = 0004.
        rom[19] = 16'h7b87;                 // str r5, r6, #7
        rom[20] = 16'h5260;                 // and r1, r1, #0      cc = z.
        rom[21] = 16'h0401;                 // brz +1 taken right after the cc write.
        rom[22] = 16'h7388;                 // str r1, r6, #8      wrong path.
        rom[23] = 16'h0201;                 // brp +1 not taken.
        rom[24] = 16'h127f;                 // add r1, r1, #-1     r1 = ffff, cc = n.
        rom[25] = 16'h0601;                 // brzp +1 not taken.
        rom[26] = 16'h7389;                 // str r1, r6, #9
        rom[27] = 16'h0801;                 // brn +1 taken.
        rom[28] = 16'h7d8a;                 // str r6, r6, #10     wrong path.
        rom[29] = 16'h1423;                 // add r2, r0, #3      loop count.
        rom[30] = 16'h16c2;                 // add r3, r3, r2      c384 + 3 + 2 + 1.
        rom[31] = 16'h14bf;                 // add r2, r2, #-1
        rom[32] = 16'h03fd;                 // brp -3 back to rom[30].
        rom[33] = 16'h778b;                 // str r3, r6, #11     r3 = c38a.
        rom[34] = 16'h758c;                 // str r2, r6, #12     r2 = 0000.
        rom[35] = 16'h0fff;                 // brnzp to self.

        // base 0008 plus offset6 times two.
        expected_address = '{16'h0008, 16'h000a, 16'h000c, 16'h000e, 16'h0010, 16'h0012,
                             16'h0014, 16'h0016, 16'h001a, 16'h001e, 16'h0020};
        expected_data    = '{16'h0002, 16'h0004, 16'h0004, 16'hfffb, 16'h0002, 16'hfffc,
                             16'hc384, 16'h0004, 16'hffff, 16'hc38a, 16'h0000};
    end

    // ##########################################################
    // clock, reset and run control
    // ##########################################################

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst         <= 1'b1;
        cycle_count = 0;
        finished    = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (!finished && cycle_count < TIMEOUT_CYCLES) begin
            @(negedge clk);                           // outputs settled here.
            cycle_count = cycle_count + 1;
            finished = (store_count == NUM_STORES) && (instr_address == HALT_PC);
        end
        if (finished) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run($sformatf(
                "Timeout after %0d cycles, program did not finish (%0d of %0d stores)",
                cycle_count, store_count, NUM_STORES));
        end
    end

    always @(posedge clk) begin
        if (rst) store_count <= 0;
        else if (store_valid) store_count <= store_count + 1;
        request_waiting <= !rst && (mem_read || mem_write) && !mem_resp;
        held_address    <= mem_address;
        held_wdata      <= mem_wdata;
    end

    // ##########################################################
    // checks
    // ##########################################################

    assert property (@(posedge clk) !rst && $past(rst) |-> !mem_read && !mem_write)
        else abort_run("Data port requested an access right after reset");
    assert property (@(posedge clk) !rst && $past(rst) |-> instr_address == 16'h0000)
        else report_mismatch("instr_address", $sampled(instr_address), 16'h0000);

    // a waiting request keeps its level, address and data.
    assert property (@(posedge clk) disable iff (rst)
                     request_waiting |-> mem_read || mem_write)
        else abort_run("Data request dropped before mem_resp");
    assert property (@(posedge clk) disable iff (rst)
                     request_waiting |-> mem_address == held_address)
        else report_mismatch("mem_address", $sampled(mem_address), $sampled(held_address));
    assert property (@(posedge clk) disable iff (rst)
                     request_waiting |-> mem_wdata == held_wdata)
        else report_mismatch("mem_wdata", $sampled(mem_wdata), $sampled(held_wdata));

    // stores arrive in program order and on the correct path only.
    assert property (@(posedge clk) store_valid |-> store_count < NUM_STORES)
        else abort_run("Store after the last expected one, a wrong-path store was written");
    assert property (@(posedge clk) store_valid && store_count < NUM_STORES |->
                     store_address == expected_address[store_count])
        else report_mismatch("store_address", $sampled(store_address),
                             $sampled(expected_address[store_count]));
    assert property (@(posedge clk) store_valid && store_count < NUM_STORES |->
                     store_data == expected_data[store_count])
        else report_mismatch("store_data", $sampled(store_data),
                             $sampled(expected_data[store_count]));

endmodule : mp3_tb

// ==== mp3.f ====
+incdir+include
logic/lc3b_types.sv
logic/pipe_reg.sv
logic/regfile.sv
logic/execute_unit.sv
logic/control.sv
logic/datapath.sv
logic/mp3.sv
bench/lc3b_memory_model.sv
bench/mp3_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mp3_tb -f mp3.f -o Vmp3_tb

output=$(./obj_dir/Vmp3_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
